// File: source/spad_pkg.sv
`default_nettype none
// ------------------------------
// Scratchpad shared definitions
// ------------------------------

package spad_pkg;

  localparam int ADDR_W   = 10;           // 1024 words
  localparam int DATA_W   = 72;           // Full URAM word
  localparam int TAG_W    = 4;            // Request tag
  localparam int NB_PIPE  = 3;            // RAM output pipeline stages
  localparam int RD_LAT   = NB_PIPE + 1;  // Sampling edge to valid response
  localparam int NB_PORTS = 2;            // Ports on the RAM

  // Request opcode, 2'b11 unused and treated as idle
  typedef enum logic [1:0] {
    OP_IDLE  = 2'd0,
    OP_WRITE = 2'd1,
    OP_READ  = 2'd2
  } spad_op_e;

  // One request per port per cycle
  typedef struct packed {
    spad_op_e            op;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   data;            // Write data only
    logic [TAG_W-1:0]    tag;             // Returned with read data
  } spad_req_t;

  // Read response
  typedef struct packed {
    logic                valid;           // One cycle per read
    logic [TAG_W-1:0]    tag;
    logic [DATA_W-1:0]   data;            // Holds last read value
  } spad_rsp_t;

  // RAM command, controller to guard to RAM
  typedef struct packed {
    logic                en;              // Memory enable
    logic                we;              // Write enable
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   data;
  } ram_cmd_t;

endpackage

`default_nettype wire

// File: source/uram.sv
`default_nettype none
// ------------------------------
// True dual-port URAM, no-change
// outputs, pipelined read path
// ------------------------------

module uram #(
  parameter int AWIDTH = spad_pkg::ADDR_W,   // Address width
  parameter int DWIDTH = spad_pkg::DATA_W,   // Data width
  parameter int NBPIPE = spad_pkg::NB_PIPE   // Output pipeline stages
) (
  input  wire logic              clk,
  input  wire logic              rsta,       // Clears both output registers
  // Port A
  input  wire logic              wea,
  input  wire logic              regcea,     // Output register enable
  input  wire logic              mem_ena,
  input  wire logic [DWIDTH-1:0] dina,
  input  wire logic [AWIDTH-1:0] addra,
  output logic      [DWIDTH-1:0] douta,
  // Port B
  input  wire logic              web,
  input  wire logic              regceb,
  input  wire logic              mem_enb,
  input  wire logic [DWIDTH-1:0] dinb,
  input  wire logic [AWIDTH-1:0] addrb,
  output logic      [DWIDTH-1:0] doutb
);

  localparam int NP = spad_pkg::NB_PORTS;

  logic [DWIDTH-1:0] mem [2**AWIDTH];        // Storage array

  // Ports gathered into arrays, index 0 is A
  logic [NP-1:0]     p_en;
  logic [NP-1:0]     p_we;
  logic [NP-1:0]     p_regce;
  logic [AWIDTH-1:0] p_addr [NP];
  logic [DWIDTH-1:0] p_din  [NP];
  logic [DWIDTH-1:0] p_dout [NP];

  assign p_en    = {mem_enb, mem_ena};
  assign p_we    = {web, wea};
  assign p_regce = {regceb, regcea};
  assign p_addr[0] = addra;
  assign p_addr[1] = addrb;
  assign p_din[0]  = dina;
  assign p_din[1]  = dinb;

  // Writes from both ports, same address never arrives from both
  always_ff @(posedge clk)
  begin
    for (int p = 0; p < NP; p++)
    begin
      if (p_en[p] && p_we[p])
        mem[p_addr[p]] <= p_din[p];
    end
  end

  for (genvar p = 0; p < NP; p++)
  begin : g_port
    logic [DWIDTH-1:0] rd_q;                 // Read register
    logic [DWIDTH-1:0] pipe_q [NBPIPE];      // Data pipeline
    logic [NBPIPE:0]   tok_q;                // Enable tokens, one per stage
    logic [DWIDTH-1:0] dout_q;               // Final output register

    // No-change, a write leaves the read register alone
    always_ff @(posedge clk)
    begin
      if (p_en[p] && !p_we[p])
        rd_q <= mem[p_addr[p]];
    end

    // Token follows every access down the pipe
    always_ff @(posedge clk)
    begin
      if (rsta)
        tok_q <= '0;
      else
        tok_q <= {tok_q[NBPIPE-1:0], p_en[p]};
    end

    always_ff @(posedge clk)
    begin
      if (tok_q[0])
        pipe_q[0] <= rd_q;
      for (int s = 1; s < NBPIPE; s++)
      begin
        if (tok_q[s])                        // Stage moves only with its token
          pipe_q[s] <= pipe_q[s-1];
      end
    end

    // Loaded only for reads, regce comes from the controller
    always_ff @(posedge clk)
    begin
      if (rsta)
        dout_q <= '0;
      else if (tok_q[NBPIPE] && p_regce[p])
        dout_q <= pipe_q[NBPIPE-1];
    end

    assign p_dout[p] = dout_q;
  end

  assign douta = p_dout[0];
  assign doutb = p_dout[1];

endmodule

`default_nettype wire

// File: source/port_ctrl.sv
`default_nettype none
// ------------------------------
// Port controller, request decode
// and in-flight read tracking
// ------------------------------

module port_ctrl (
  input  wire logic                     clk,
  input  wire logic                     rsta,
  input  wire spad_pkg::spad_req_t      req,
  input  wire logic [spad_pkg::DATA_W-1:0] dout,   // From RAM output register
  output spad_pkg::ram_cmd_t            cmd,
  output logic                          regce,
  output spad_pkg::spad_rsp_t           rsp
);

  localparam int LAT = spad_pkg::RD_LAT;

  logic is_rd;
  logic is_wr;

  // In-flight chain, index is age in edges after the sampling edge
  logic [LAT:0]                rd_vld;
  logic [spad_pkg::TAG_W-1:0]  rd_tag [LAT+1];

  // Opcode decode, reserved code acts as idle
  assign is_rd = (req.op == spad_pkg::OP_READ);
  assign is_wr = (req.op == spad_pkg::OP_WRITE);

  always_comb
  begin
    cmd.en   = is_rd | is_wr;
    cmd.we   = is_wr;
    cmd.addr = req.addr;
    cmd.data = req.data;
  end

  // Read flag and tag shift along with the RAM pipeline
  always_ff @(posedge clk)
  begin
    if (rsta)
    begin
      rd_vld <= '0;
      for (int i = 0; i <= LAT; i++)
        rd_tag[i] <= '0;
    end
    else
    begin
      rd_vld    <= {rd_vld[LAT-1:0], is_rd};
      rd_tag[0] <= req.tag;
      for (int i = 1; i <= LAT; i++)
        rd_tag[i] <= rd_tag[i-1];
    end
  end

  // Second-to-last stage lines up with the RAM's last token
  assign regce = rd_vld[LAT-1];

  // Last stage matches the cycle after the output register loads
  always_comb
  begin
    rsp.valid = rd_vld[LAT];
    rsp.tag   = rd_tag[LAT];
    rsp.data  = dout;                        // Holds between reads
  end

endmodule

`default_nettype wire

// File: source/collision_guard.sv
`default_nettype none
// ------------------------------
// Dual-write collision guard,
// port A has fixed priority
// ------------------------------

module collision_guard (
  input  wire spad_pkg::ram_cmd_t cmd_a_in,
  input  wire spad_pkg::ram_cmd_t cmd_b_in,
  output spad_pkg::ram_cmd_t      cmd_a_out,
  output spad_pkg::ram_cmd_t      cmd_b_out,
  output logic                    coll       // Combinational, one per hit
);

  logic wr_a;
  logic wr_b;
  logic same_addr;

  assign wr_a      = cmd_a_in.en & cmd_a_in.we;
  assign wr_b      = cmd_b_in.en & cmd_b_in.we;
  assign same_addr = (cmd_a_in.addr == cmd_b_in.addr);

  // One write per address per cycle
  assign coll = wr_a & wr_b & same_addr;

  // Port A always goes through
  assign cmd_a_out = cmd_a_in;

  // Drop B's write on a hit, the access becomes idle
  always_comb
  begin
    cmd_b_out = cmd_b_in;
    if (coll)
    begin
      cmd_b_out.en = 1'b0;
      cmd_b_out.we = 1'b0;
    end
  end

  // Read/write pairs across ports not handled here

endmodule

`default_nettype wire

// File: source/spad_top.sv
`default_nettype none
// ------------------------------
// Dual-port scratchpad top
// ------------------------------

module spad_top (
  input  wire logic                clk,
  input  wire logic                rsta,
  input  wire spad_pkg::spad_req_t req_a,
  input  wire spad_pkg::spad_req_t req_b,
  output spad_pkg::spad_rsp_t      rsp_a,
  output spad_pkg::spad_rsp_t      rsp_b,
  output logic                     coll
);

  spad_pkg::ram_cmd_t cmd_a;                 // Controller commands
  spad_pkg::ram_cmd_t cmd_b;
  spad_pkg::ram_cmd_t ram_a;                 // Guarded commands
  spad_pkg::ram_cmd_t ram_b;

  logic                        regcea;
  logic                        regceb;
  logic [spad_pkg::DATA_W-1:0] douta;
  logic [spad_pkg::DATA_W-1:0] doutb;

  port_ctrl ctrl_a (
    .clk   (clk),
    .rsta  (rsta),
    .req   (req_a),
    .dout  (douta),
    .cmd   (cmd_a),
    .regce (regcea),
    .rsp   (rsp_a)
  );

  port_ctrl ctrl_b (
    .clk   (clk),
    .rsta  (rsta),
    .req   (req_b),
    .dout  (doutb),
    .cmd   (cmd_b),
    .regce (regceb),
    .rsp   (rsp_b)
  );

  collision_guard guard (
    .cmd_a_in  (cmd_a),
    .cmd_b_in  (cmd_b),
    .cmd_a_out (ram_a),
    .cmd_b_out (ram_b),
    .coll      (coll)
  );

  // Sizes come from the package defaults
  uram ram (
    .clk     (clk),
    .rsta    (rsta),
    .wea     (ram_a.we),
    .regcea  (regcea),
    .mem_ena (ram_a.en),
    .dina    (ram_a.data),
    .addra   (ram_a.addr),
    .douta   (douta),
    .web     (ram_b.we),
    .regceb  (regceb),
    .mem_enb (ram_b.en),
    .dinb    (ram_b.data),
    .addrb   (ram_b.addr),
    .doutb   (doutb)
  );

endmodule

`default_nettype wire

// File: sim/spad_props.sv
`default_nettype none
// ------------------------------
// Response timing and collision
// assertions for the scratchpad
// ------------------------------

module spad_props (
  input wire logic                clk,
  input wire logic                rsta,
  input wire spad_pkg::spad_req_t req_a,
  input wire spad_pkg::spad_req_t req_b,
  input wire spad_pkg::spad_rsp_t rsp_a,
  input wire spad_pkg::spad_rsp_t rsp_b,
  input wire logic                coll,
  input wire spad_pkg::ram_cmd_t  ram_b       // After the guard
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned age;                           // Edges since reset
  logic        dual_wr;                       // Both ports write one address

  always_ff @(posedge clk)
  begin
    if (rsta)
      age <= 0;
    else if (age < 100)
      age <= age + 1;
  end

  // Taken from the requests at the top level
  assign dual_wr = (req_a.op == spad_pkg::OP_WRITE) && (req_b.op == spad_pkg::OP_WRITE)
                   && (req_a.addr == req_b.addr);

  // Valid seen one edge after the response cycle starts
  a_lat_a: assert property (@(posedge clk) disable iff (rsta)
    (age > spad_pkg::RD_LAT) |->
      (rsp_a.valid == $past(req_a.op == spad_pkg::OP_READ, spad_pkg::RD_LAT + 1)))
    else $error("Port A response valid not RD_LAT after its read");

  a_lat_b: assert property (@(posedge clk) disable iff (rsta)
    (age > spad_pkg::RD_LAT) |->
      (rsp_b.valid == $past(req_b.op == spad_pkg::OP_READ, spad_pkg::RD_LAT + 1)))
    else $error("Port B response valid not RD_LAT after its read");

  a_coll_cause: assert property (@(posedge clk) disable iff (rsta)
    coll |-> dual_wr)
    else $error("Collision flagged without two writes to one address");

  a_coll_drop: assert property (@(posedge clk) disable iff (rsta)
    dual_wr |-> (coll && !(ram_b.en && ram_b.we)))
    else $error("Port B write reached the RAM during a collision");

endmodule

`default_nettype wire

// File: sim/spad_tb.sv
`default_nettype none
// ------------------------------
// Scratchpad testbench running directed
// and LFSR traffic against a model
// ------------------------------

module spad_tb;
  timeunit 1ns;
  timeprecision 1ps;

  logic                        clk;
  logic                        rsta;
  spad_pkg::spad_req_t         req_a;
  spad_pkg::spad_req_t         req_b;
  spad_pkg::spad_rsp_t         rsp_a;
  spad_pkg::spad_rsp_t         rsp_b;
  logic                        coll;

  logic [15:0]                 lfsr_q;                          // Stimulus LFSR
  logic [spad_pkg::DATA_W-1:0] mirror [2**spad_pkg::ADDR_W];   // Model memory
  logic [spad_pkg::DATA_W-1:0] last_a;                          // Held output data
  logic [spad_pkg::DATA_W-1:0] last_b;
  spad_pkg::spad_rsp_t         exp_a [$];                       // One entry per cycle
  spad_pkg::spad_rsp_t         exp_b [$];
  logic                        exp_coll [$];
  spad_pkg::spad_rsp_t         cmp_a;
  spad_pkg::spad_rsp_t         cmp_b;
  spad_pkg::spad_req_t         idle;
  spad_pkg::spad_req_t         ra;
  spad_pkg::spad_req_t         rb;
  int                          pend;                            // Reads not yet compared
  int                          wait_cnt;
  logic                        checking;

  spad_top uut (
    .clk   (clk),
    .rsta  (rsta),
    .req_a (req_a),
    .req_b (req_b),
    .rsp_a (rsp_a),
    .rsp_b (rsp_b),
    .coll  (coll)
  );

  bind spad_top spad_props props (
    .clk   (clk),
    .rsta  (rsta),
    .req_a (req_a),
    .req_b (req_b),
    .rsp_a (rsp_a),
    .rsp_b (rsp_b),
    .coll  (coll),
    .ram_b (ram_b)
  );

  always #50 clk = ~clk;                    // 100 ns period

  // Fibonacci taps 16 14 13 11 stepped once per bit
  function automatic logic [spad_pkg::DATA_W-1:0] take_bits(input int n);
    logic [spad_pkg::DATA_W-1:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
      v      = {v[spad_pkg::DATA_W-2:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic spad_pkg::spad_req_t make_req(
    input spad_pkg::spad_op_e          op,
    input logic [spad_pkg::ADDR_W-1:0] addr,
    input logic [spad_pkg::DATA_W-1:0] data,
    input logic [spad_pkg::TAG_W-1:0]  tag
  );
    spad_pkg::spad_req_t r;
    r.op   = op;
    r.addr = addr;
    r.data = data;
    r.tag  = tag;
    return r;
  endfunction

  function automatic spad_pkg::spad_req_t random_req();
    spad_pkg::spad_req_t         r;
    logic [spad_pkg::DATA_W-1:0] sel;
    logic [spad_pkg::DATA_W-1:0] adr;
    logic [spad_pkg::DATA_W-1:0] tg;
    sel = take_bits(2);
    adr = take_bits(3);
    case (sel[1:0])
      2'd0:    r.op = spad_pkg::OP_IDLE;
      2'd1:    r.op = spad_pkg::OP_WRITE;
      default: r.op = spad_pkg::OP_READ;    // Reads weighted double
    endcase
    r.addr = {7'h20, adr[2:0]};             // Eight-word window at 0x100
    r.data = take_bits(spad_pkg::DATA_W);
    tg     = take_bits(spad_pkg::TAG_W);
    r.tag  = tg[spad_pkg::TAG_W-1:0];
    return r;
  endfunction

  // Read sees the array before this cycle's writes
  function automatic spad_pkg::spad_rsp_t expect_rsp(
    input spad_pkg::spad_req_t          r,
    inout logic [spad_pkg::DATA_W-1:0]  last
  );
    spad_pkg::spad_rsp_t e;
    e = '0;
    if (r.op == spad_pkg::OP_READ)
    begin
      last    = mirror[r.addr];
      e.valid = 1'b1;
      e.tag   = r.tag;
      pend++;
    end
    e.data = last;                          // No-change hold otherwise
    return e;
  endfunction

  // Reference model for one cycle of requests
  function automatic void predict(input spad_pkg::spad_req_t a, input spad_pkg::spad_req_t b);
    logic wa;
    logic wb;
    exp_a.push_back(expect_rsp(a, last_a));
    exp_b.push_back(expect_rsp(b, last_b));
    wa = (a.op == spad_pkg::OP_WRITE);
    wb = (b.op == spad_pkg::OP_WRITE);
    exp_coll.push_back(wa && wb && (a.addr == b.addr));
    if (wb)
      mirror[b.addr] = b.data;
    if (wa)
      mirror[a.addr] = a.data;              // A applied last so A wins
  endfunction

  task automatic drive_cycle(input spad_pkg::spad_req_t a, input spad_pkg::spad_req_t b);
    @(negedge clk);
    req_a <= a;
    req_b <= b;
    predict(a, b);
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_rsp(input string port, input spad_pkg::spad_rsp_t got,
                           input spad_pkg::spad_rsp_t exp);
    if (got.valid !== exp.valid || got.data !== exp.data || (exp.valid && got.tag !== exp.tag))
      abort_run($sformatf("FAILED at %0t ns: port %s response %h, expected %h",
                          $time, port, got, exp));
  endtask

  task automatic check_coll(input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("FAILED at %0t ns: coll %b, expected %b", $time, got, exp));
  endtask

  // Outputs stable here while new inputs land in the NBA region
  always @(negedge clk)
  begin
    if (checking)
    begin
      cmp_a = exp_a.pop_front();
      cmp_b = exp_b.pop_front();
      check_rsp("A", rsp_a, cmp_a);
      check_rsp("B", rsp_b, cmp_b);
      check_coll(coll, exp_coll.pop_front());
      if (cmp_a.valid)
        pend--;
      if (cmp_b.valid)
        pend--;
    end
  end

  initial
  begin
    clk      = 1'b0;
    rsta     = 1'b1;
    idle     = make_req(spad_pkg::OP_IDLE, '0, '0, '0);
    req_a    = idle;
    req_b    = idle;
    lfsr_q   = 16'd82;
    last_a   = '0;
    last_b   = '0;
    pend     = 0;
    checking = 1'b0;
    for (int i = 0; i <= spad_pkg::RD_LAT; i++)   // Idle cycles already in the pipe
    begin
      exp_a.push_back('0);
      exp_b.push_back('0);
    end
    exp_coll.push_back(1'b0);
    repeat (2) @(posedge clk);
    @(negedge clk);
    rsta <= 1'b0;
    @(posedge clk);
    checking = 1'b1;

    repeat (4) drive_cycle(idle, idle);     // No response before any read
    for (int i = 0; i < 8; i += 2)          // Fill window with even words from A and odd from B
      drive_cycle(make_req(spad_pkg::OP_WRITE, 10'h100 + 10'(i), take_bits(72), 4'd0),
                  make_req(spad_pkg::OP_WRITE, 10'h101 + 10'(i), take_bits(72), 4'd0));
    // Write then read on one port
    drive_cycle(make_req(spad_pkg::OP_WRITE, 10'h2A5, 72'h11_2233_4455_6677_8899, 4'd0), idle);
    drive_cycle(make_req(spad_pkg::OP_READ, 10'h2A5, '0, 4'h5), idle);
    // Back-to-back reads on B then write, idle and read
    for (int i = 0; i < 4; i++)
      drive_cycle(idle, make_req(spad_pkg::OP_READ, 10'h100 + 10'(i), '0, 4'(i + 1)));
    drive_cycle(idle, make_req(spad_pkg::OP_WRITE, 10'h3C0, 72'hFE_DCBA_9876_5432_1001, 4'd0));
    drive_cycle(idle, idle);
    drive_cycle(idle, make_req(spad_pkg::OP_READ, 10'h3C0, '0, 4'h9));
    // Cross-port visibility both ways
    drive_cycle(make_req(spad_pkg::OP_WRITE, 10'h155, 72'hA5_A5A5_5A5A_A5A5_5A5A, 4'd0), idle);
    drive_cycle(idle, make_req(spad_pkg::OP_READ, 10'h155, '0, 4'h6));
    drive_cycle(idle, make_req(spad_pkg::OP_WRITE, 10'h0AA, 72'h3C_0FF0_C33C_0FF0_C33C, 4'd0));
    drive_cycle(make_req(spad_pkg::OP_READ, 10'h0AA, '0, 4'h7), idle);
    // Same-address dual write where A must win
    drive_cycle(make_req(spad_pkg::OP_WRITE, 10'h300, 72'hAA_0000_0000_0000_00AA, 4'd0),
                make_req(spad_pkg::OP_WRITE, 10'h300, 72'hBB_0000_0000_0000_00BB, 4'd0));
    drive_cycle(make_req(spad_pkg::OP_READ, 10'h300, '0, 4'h8),
                make_req(spad_pkg::OP_READ, 10'h300, '0, 4'hC));

    for (int n = 0; n < 400; n++)           // Random traffic in the window
    begin
      ra = random_req();
      rb = random_req();
      if (ra.op == spad_pkg::OP_WRITE && rb.op == spad_pkg::OP_READ && ra.addr == rb.addr)
        rb.addr[0] = ~rb.addr[0];           // Keep cross-port read/write apart
      if (rb.op == spad_pkg::OP_WRITE && ra.op == spad_pkg::OP_READ && ra.addr == rb.addr)
        ra.addr[0] = ~ra.addr[0];
      drive_cycle(ra, rb);
    end

    wait_cnt = 0;
    while (pend > 0 && wait_cnt < 4 * spad_pkg::RD_LAT)   // Drain outstanding reads
    begin
      drive_cycle(idle, idle);
      wait_cnt++;
    end
    if (pend > 0)
      abort_run("Timeout while waiting for outstanding read responses");
    else
    begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: build.f
source/spad_pkg.sv
source/uram.sv
source/port_ctrl.sv
source/collision_guard.sv
source/spad_top.sv
sim/spad_props.sv
sim/spad_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the scratchpad testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --assert --top-module spad_tb -f build.f -o spad_sim > build.log 2>&1 \
  && ./obj_dir/spad_sim > sim.log 2>&1 \
  || echo "Test failed" >> sim.log
cat build.log sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
